// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary -f src.f --top-module tbUartTxArray -o simv &&
./obj_dir/simv > sim.log 2>&1 ||
echo "Build or simulation returned an error status." >&2
cat sim.log 2>/dev/null
grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1

// File: src.f
+incdir+.
uartPkg.sv
txDispatcher.sv
uartTxLane.sv
txDoneCollector.sv
uartTxArray.sv
tbUartTxArray.sv

// File: tbUartTxArray.sv
`default_nettype none

`include "uart_defs.svh"

module tbUartTxArray;
    import uartPkg::*;

    localparam int clkPeriod = 8;
    localparam int frameCycles = 10 * `CLKS_PER_BIT + 2;
    localparam int drainLimit = 4 * frameCycles;
    localparam int idleLimit = 100000;

    logic     clk;
    logic     arstN;
    logic     reqValid;
    txReqT    req;
    laneMaskT txd;
    laneMaskT busy;
    logic     reject;
    logic     doneValid;
    txDoneT   done;

    int   cycleNow = 0;
    logic monitorOn = 1'b0;
    logic expReject = 1'b0;
    logic rejectQ[$];
    byteT expQ[`NUM_LANES][$];
    byteT rxQ[`NUM_LANES][$];
    int   acceptCnt[`NUM_LANES];
    int   frameCnt[`NUM_LANES];
    int   doneCnt[`NUM_LANES];
    int   busyFrom[`NUM_LANES];
    int   busyTo[`NUM_LANES];
    int   finishCycle[`NUM_LANES];

    uartTxArray DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) cycleNow <= cycleNow + 1;

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // ################################################
    // Request driver and lane timing model.
    // ################################################

    task automatic sendRequest(input laneIdT lane, input byteT data, input logic flag);
        int   reqCycle;
        logic predicted;
        @(posedge clk);
        reqCycle = cycleNow + 1;
        // Busy from the start pulse until ready returns.
        predicted = (reqCycle <= busyTo[lane]);
        assert (predicted == flag)
            else failNow($sformatf("FAIL %0t: stim reject flag %0b for lane %0d does not fit timing",
                                   $time, flag, lane));
        rejectQ.push_back(predicted);
        if (!predicted) begin
            expQ[lane].push_back(data);
            acceptCnt[lane]++;
            busyFrom[lane] = reqCycle + 2;
            busyTo[lane] = reqCycle + frameCycles;
        end
        reqValid <= 1'b1;
        req.laneId <= lane;
        req.data <= data;
    endtask

    task automatic drainArray();
        int   waited;
        int   l;
        logic idle;
        @(posedge clk);
        reqValid <= 1'b0;
        waited = 0;
        idle = 1'b0;
        while (!idle && waited < drainLimit) begin
            @(posedge clk);
            waited++;
            idle = 1'b1;
            for (l = 0; l < `NUM_LANES; l++) begin
                if (cycleNow <= busyTo[l] || expQ[l].size() != 0 ||
                    doneCnt[l] != acceptCnt[l]) begin
                    idle = 1'b0;
                end
            end
        end
        if (!idle) failNow("Timeout: the array did not return to idle.");
    endtask

    // ################################################
    // Per-cycle output monitor.
    // ################################################

    task automatic noteCompletion(input laneIdT lane);
        assert (doneCnt[lane] < frameCnt[lane])
            else failNow($sformatf("FAIL %0t: completion for lane %0d without a frame", $time, lane));
        // One start per cycle, so no two lanes are ever pending together.
        assert (cycleNow == finishCycle[lane] + 1)
            else failNow($sformatf("FAIL %0t: lane %0d completion latency is not one cycle",
                                   $time, lane));
        doneCnt[lane]++;
    endtask

    task automatic checkCycle();
        laneMaskT expBusy;
        int       l;
        for (l = 0; l < `NUM_LANES; l++) begin
            expBusy[l] = (cycleNow >= busyFrom[l] && cycleNow <= busyTo[l]);
        end
        assert (busy === expBusy)
            else failNow($sformatf("FAIL %0t: busy %b, expected %b", $time, busy, expBusy));
        // Idle lines stay high.
        assert ((txd | expBusy) === '1)
            else failNow($sformatf("FAIL %0t: txd %b low on an idle lane", $time, txd));
        assert (reject === expReject)
            else failNow($sformatf("FAIL %0t: reject %b, expected %b", $time, reject, expReject));
        expReject = 1'b0;
        if (reqValid === 1'b1) begin
            expReject = rejectQ.pop_front();
        end
        if (doneValid === 1'b1) noteCompletion(done.laneId);
    endtask

    always @(negedge clk) begin
        if (monitorOn) checkCycle();
    end

    // ################################################
    // Serial decoders, one per lane.
    // ################################################

    // Holds a bit for a full period and returns its level.
    task automatic holdBit(input laneIdT lane, output logic bitVal);
        logic first;
        first = txd[lane];
        repeat (`CLKS_PER_BIT - 1) begin
            @(negedge clk);
            assert (txd[lane] === first)
                else failNow($sformatf("FAIL %0t: lane %0d bit shorter than %0d cycles",
                                       $time, lane, `CLKS_PER_BIT));
        end
        bitVal = first;
    endtask

    task automatic checkFrame(input laneIdT lane);
        byteT got;
        byteT want;
        got = rxQ[lane].pop_front();
        assert (expQ[lane].size() != 0)
            else failNow($sformatf("FAIL %0t: lane %0d sent %h, never accepted", $time, lane, got));
        want = expQ[lane].pop_front();
        assert (got === want)
            else failNow($sformatf("FAIL %0t: lane %0d sent %h, expected %h", $time, lane, got, want));
    endtask

    task automatic decodeLane(input laneIdT lane);
        int   waited;
        int   i;
        logic bitVal;
        byteT rxByte;
        forever begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (txd[lane] !== 1'b0 && waited < idleLimit);
            if (txd[lane] !== 1'b0) failNow("Timeout: a lane decoder saw no start bit.");
            assert (cycleNow == busyFrom[lane])
                else failNow($sformatf("FAIL %0t: lane %0d start bit at wrong cycle", $time, lane));
            holdBit(lane, bitVal);
            for (i = 0; i < `DATA_BITS; i++) begin
                @(negedge clk);
                holdBit(lane, bitVal);
                rxByte[i] = bitVal;
            end
            @(negedge clk);
            holdBit(lane, bitVal);
            assert (bitVal === 1'b1)
                else failNow($sformatf("FAIL %0t: lane %0d stop bit is low", $time, lane));
            finishCycle[lane] = cycleNow + 1;
            frameCnt[lane]++;
            rxQ[lane].push_back(rxByte);
            checkFrame(lane);
        end
    endtask

    for (genvar g = 0; g < `NUM_LANES; g++) begin : genDecoder
        initial decodeLane(laneIdT'(g));
    end

    // ################################################
    // Main sequence.
    // ################################################

    initial begin
        int    fd;
        int    lane;
        int    data;
        int    flag;
        int    gap;
        int    l;
        string line;
        void'($urandom(32'hd6a2));
        arstN = 1'b0;
        reqValid = 1'b0;
        req = '0;
        acceptCnt = '{default: 0};
        frameCnt = '{default: 0};
        doneCnt = '{default: 0};
        busyFrom = '{default: 0};
        busyTo = '{default: -1};
        finishCycle = '{default: 0};
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        assert (txd === '1 && busy === '0 && reject === 1'b0 && doneValid === 1'b0)
            else failNow($sformatf("FAIL %0t: outputs not at reset values", $time));
        monitorOn = 1'b1;

        fd = $fopen("uart_stim.txt", "r");
        if (fd == 0) failNow("Could not open uart_stim.txt for reading.");
        while ($fgets(line, fd) != 0) begin
            if (line.len() >= 4 && line.substr(0, 3) == "idle") begin
                drainArray();
                gap = $urandom_range(7, 0);
                repeat (gap) @(posedge clk);
            end else if ($sscanf(line, "%h %h %h", lane, data, flag) == 3) begin
                sendRequest(laneIdT'(lane), byteT'(data), flag[0]);
            end
        end
        $fclose(fd);
        drainArray();

        for (l = 0; l < `NUM_LANES; l++) begin
            assert (doneCnt[l] == acceptCnt[l] && frameCnt[l] == acceptCnt[l])
                else failNow($sformatf("FAIL %0t: lane %0d had %0d accepted, %0d frames, %0d done",
                                       $time, l, acceptCnt[l], frameCnt[l], doneCnt[l]));
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: txDispatcher.sv
`default_nettype none

module txDispatcher (
    input  logic              clk,
    input  logic              arstN,
    input  logic              reqValid,
    input  uartPkg::txReqT    req,
    input  uartPkg::laneMaskT laneReady,
    output uartPkg::laneMaskT laneStart,
    output uartPkg::byteT     laneData,
    output logic              reject
);
    import uartPkg::*;

    laneMaskT reqSel;
    laneMaskT laneFree;
    logic     accept;

    // One-hot select of the addressed lane.
    assign reqSel = laneMaskT'(1) << req.laneId;

    // A lane started last cycle still shows ready for one more cycle.
    assign laneFree = laneReady & ~laneStart;
    assign accept = |(reqSel & laneFree);

    // ################################################
    // Start and reject pulses.
    // ################################################

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            laneStart <= '0;
            reject <= 1'b0;
        end else begin
            if (reqValid && accept) begin
                laneStart <= reqSel;
            end else begin
                laneStart <= '0;
            end
            reject <= reqValid && !accept;
        end
    end

    // Shared data byte, valid alongside the start pulse.
    always_ff @(posedge clk) begin
        if (reqValid) begin
            laneData <= req.data;
        end
    end

endmodule

`default_nettype wire

// File: txDoneCollector.sv
`default_nettype none

`include "uart_defs.svh"

module txDoneCollector (
    input  logic              clk,
    input  logic              arstN,
    input  uartPkg::laneMaskT laneDone,
    output logic              doneValid,
    output uartPkg::txDoneT   done
);
    import uartPkg::*;

    laneMaskT pending;
    laneMaskT merged;
    laneMaskT pickMask;
    laneIdT   pickId;

    assign merged = pending | laneDone;

    // Lowest set bit wins.
    always_comb begin
        pickId = '0;
        for (int i = `NUM_LANES - 1; i >= 0; i--) begin
            if (merged[i]) begin
                pickId = laneIdT'(i);
            end
        end
    end

    assign pickMask = (|merged) ? (laneMaskT'(1) << pickId) : '0;

    // ################################################
    // Pending mask and completion output.
    // ################################################

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pending <= '0;
            doneValid <= 1'b0;
        end else begin
            pending <= merged & ~pickMask;
            doneValid <= |merged;
        end
    end

    always_ff @(posedge clk) begin
        done.laneId <= pickId;
    end

endmodule

`default_nettype wire

// File: uartPkg.sv
`default_nettype none

`include "uart_defs.svh"

package uartPkg;

    typedef logic [`DATA_BITS-1:0] byteT;
    typedef logic [`LANE_ID_BITS-1:0] laneIdT;
    typedef logic [`NUM_LANES-1:0] laneMaskT;

    // Holds values up to CLKS_PER_BIT.
    typedef logic [$clog2(`CLKS_PER_BIT + 1)-1:0] bitCntT;

    typedef struct packed {
        laneIdT laneId;
        byteT   data;
    } txReqT;

    typedef struct packed {
        laneIdT laneId;
    } txDoneT;

    typedef enum logic [2:0] {
        Idle,
        Start,
        Data,
        Stop,
        Recover
    } txStateT;

endpackage

`default_nettype wire

// File: uartTxArray.sv
`default_nettype none

`include "uart_defs.svh"

module uartTxArray (
    input  logic              clk,
    input  logic              arstN,
    input  logic              reqValid,
    input  uartPkg::txReqT    req,
    output uartPkg::laneMaskT txd,
    output uartPkg::laneMaskT busy,
    output logic              reject,
    output logic              doneValid,
    output uartPkg::txDoneT   done
);
    import uartPkg::*;

    laneMaskT laneStart;
    laneMaskT laneReady;
    laneMaskT laneDone;
    byteT     laneData;

    assign busy = ~laneReady;

    txDispatcher dispatcher (
        .clk       (clk),
        .arstN     (arstN),
        .reqValid  (reqValid),
        .req       (req),
        .laneReady (laneReady),
        .laneStart (laneStart),
        .laneData  (laneData),
        .reject    (reject)
    );

    // ################################################
    // Transmit lanes.
    // ################################################

    for (genvar i = 0; i < `NUM_LANES; i++) begin : genLane
        uartTxLane lane (
            .clk   (clk),
            .arstN (arstN),
            .start (laneStart[i]),
            .data  (laneData),
            .txd   (txd[i]),
            .ready (laneReady[i]),
            .done  (laneDone[i])
        );
    end

    txDoneCollector collector (
        .clk       (clk),
        .arstN     (arstN),
        .laneDone  (laneDone),
        .doneValid (doneValid),
        .done      (done)
    );

endmodule

`default_nettype wire

// File: uartTxLane.sv
`default_nettype none

`include "uart_defs.svh"

module uartTxLane (
    input  logic          clk,
    input  logic          arstN,
    input  logic          start,
    input  uartPkg::byteT data,
    output logic          txd,
    output logic          ready,
    output logic          done
);
    import uartPkg::*;

    localparam int bitIdxW = $clog2(`DATA_BITS);
    localparam logic [bitIdxW-1:0] lastBit = bitIdxW'(`DATA_BITS - 1);

    txStateT            state;
    bitCntT             cycleCnt;
    logic [bitIdxW-1:0] bitIdx;
    byteT               shiftReg;
    logic               bitEnd;

    // Last cycle of the current bit period.
    assign bitEnd = (cycleCnt == bitCntT'(`CLKS_PER_BIT - 1));

    assign ready = (state == Idle);
    assign done = (state == Recover);

    // ################################################
    // Frame state machine.
    // ################################################

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= Idle;
            txd <= 1'b1;
            cycleCnt <= '0;
            bitIdx <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (start) begin
                        // Start bit goes out on the next cycle.
                        state <= Start;
                        txd <= 1'b0;
                        cycleCnt <= '0;
                    end
                end
                Start: begin
                    if (bitEnd) begin
                        state <= Data;
                        txd <= shiftReg[0];
                        bitIdx <= '0;
                        cycleCnt <= '0;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                Data: begin
                    if (bitEnd) begin
                        cycleCnt <= '0;
                        if (bitIdx == lastBit) begin
                            state <= Stop;
                            txd <= 1'b1;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                            txd <= shiftReg[1];
                        end
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                Stop: begin
                    if (bitEnd) begin
                        state <= Recover;
                        cycleCnt <= '0;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                Recover: begin
                    state <= Idle;
                end
                default: begin
                    state <= Idle;
                    txd <= 1'b1;
                end
            endcase
        end
    end

    // Data shifter, LSB first.
    always_ff @(posedge clk) begin
        if (state == Idle && start) begin
            shiftReg <= data;
        end else if (state == Data && bitEnd) begin
            shiftReg <= shiftReg >> 1;
        end
    end

endmodule

`default_nettype wire

// File: uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// ################################################
// Array geometry.
// ################################################

// Number of independent transmit lanes.
`define NUM_LANES 4

// Width of a lane index, log2 of the lane count.
`define LANE_ID_BITS 2

// ################################################
// Serial framing.
// ################################################

// Clock cycles per serial bit.
`define CLKS_PER_BIT 8

// Bits per character.
`define DATA_BITS 8

`endif

// File: uart_stim.txt
# Columns: laneId data expectedReject, all in hex.
# A line reading idle waits until every lane is idle and all completions are in.
idle
0 a5 0
idle
2 3c 0
2 ff 1
2 11 1
idle
0 55 0
1 aa 0
2 0f 0
3 f0 0
1 77 1
idle
3 81 0
2 42 0
1 24 0
0 18 0
3 99 1
idle
1 00 0
1 ff 1
idle
3 ff 0
0 01 0
0 fe 1
idle
